// File: all.f
src/accel_pkg.sv
src/accel_regs.sv
src/pkt_rd_dma.sv
src/sig_matcher.sv
src/ip_blocklist.sv
src/accel_wrap.sv
bench/accel_wrap_tb.sv

// File: bench/accel_stimulus.txt
# kind name addr data expect, numbers in hex
# M loads a packet memory line, W writes, R reads a word, I reads the hit index
M mem 010 adde0201 0
M mem 011 0403efbe 0
M mem 012 efbeadde 0
M mem 013 00000005 0
M mem 020 2211efbe 0
M mem 021 efbeadde 0
M mem 030 40302010 0
M mem 031 00006050 0
W rb_len 004 00000123 0
R rb_len 004 0 00000123
W rb_addr 008 000000a5 0
R rb_addr 008 0 000000a5
W rb_pat 010 deadbeef 0
R rb_pat 010 0 deadbeef
W rb_pre 014 12345678 0
R rb_pre 014 0 12345678
W a_addr 008 00000010 0
W a_len 004 0000000d 0
W a_pre 014 00000000 0
W a_start 000 00000001 0
I a_hit1 00c 0 00000005
R a_ctrl 000 0 00000202
W a_rel1 028 00000001 0
I a_hit2 00c 0 0000000b
W a_rel2 028 00000001 0
I a_drain 00c 0 0000000b
R a_done 000 0 00000100
W b_addr 008 00000020 0
W b_len 004 00000008 0
W b_pre 014 1122dead 0
W b_start 000 00000001 0
I b_hit1 00c 0 00000001
W b_rel 028 00000001 0
I b_hit2 00c 0 00000007
R b_ctrl 000 0 00000300
W c_addr 008 00000030 0
W c_len 004 00000006 0
W c_pre 014 00000000 0
W c_start 000 00000001 0
I c_wait 00c 0 00000007
R c_ctrl 000 0 00000100
R c_state 018 0 30405060
W ip_listed 800 010aa8c0 0
R ip_hit 800 0 00000001
W ip_unlisted 800 020aa8c0 0
R ip_miss 800 0 00000000
W z_len 004 00000000 0
W z_start 000 00000001 0
R z_len_rd 004 0 00000000
R z_err 404 0 00000001
W s_addr 008 00000040 0
W s_len 004 000000c8 0
W s_start 000 00000001 0
R s_len_rd 004 0 000000c8
R s_busy 000 0 00000002
W s_stop 000 00000010 0
R s_err 404 0 00000000
R s_ctrl 000 0 00000100

// File: bench/accel_wrap_tb.sv
module accel_wrap_tb
  import accel_pkg::*;
();

  logic                  clk;
  logic                  rst;
  logic                  io_en;
  logic                  io_wen;
  logic [io_strb_w-1:0]  io_strb;
  logic [io_addr_w-1:0]  io_addr;
  logic [io_data_w-1:0]  io_wr_data;
  logic [io_data_w-1:0]  io_rd_data;
  logic                  io_rd_valid;
  logic                  mem_en;
  logic [mem_addr_w-1:0] mem_addr;
  logic [io_data_w-1:0]  mem_rd_data;

  // packet memory model
  logic [io_data_w-1:0]  mem_img [256];
  logic                  mem_req;
  logic [mem_addr_w-1:0] mem_line;
  int                    mem_lines;

  // test lines from the data file
  string                 t_kind [$];
  string                 t_name [$];
  logic [io_addr_w-1:0]  t_addr [$];
  logic [io_data_w-1:0]  t_data [$];
  logic [io_data_w-1:0]  t_exp [$];

  // what the core has programmed so far
  logic [mem_addr_w-1:0] cur_addr;
  int                    cur_len;
  logic [io_data_w-1:0]  cur_pat;
  logic [io_data_w-1:0]  cur_pre;
  int                    hit_num;
  match_idx_t            model_idx;

  int                    cycle_count;
  int                    cycle_limit;

  accel_wrap i_accel_wrap (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_rd_data(mem_rd_data)
  );

  always #2 clk = ~clk;

  // read data shows up one cycle after the request
  always @(negedge clk) begin
    // reads walk the packet upward, one line in flight
    if (mem_en && !rst) begin
      if (mem_req) begin
        stop_on_error("packet memory read issued with another line in flight");
      end
      check_line("mem_addr", mem_addr_w'(cur_addr + mem_lines), mem_addr);
      mem_lines = mem_lines + 1;
      if (mem_lines > (cur_len + 3) / 4) begin
        stop_on_error("read engine read past the end of the packet");
      end
    end
    if (mem_req) begin
      mem_rd_data <= mem_img[mem_line];
    end
    mem_req  <= mem_en;
    mem_line <= mem_addr;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      stop_on_error($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [io_data_w-1:0] exp,
                            input logic [io_data_w-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_idx(input string name, input match_idx_t exp, input match_idx_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("error: %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_line(input string name, input logic [mem_addr_w-1:0] exp,
                            input logic [mem_addr_w-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic write_reg(input logic [io_addr_w-1:0] addr, input logic [io_data_w-1:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // address stays put until the answer comes back
  task automatic read_reg(input logic [io_addr_w-1:0] addr, output logic [io_data_w-1:0] data);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    while (!io_rd_valid) begin
      @(negedge clk);
    end
    data = io_rd_data;
  endtask

  // slide the window over the packet, keep the offset of hit number n
  task automatic model_scan(input int n, output logic [io_data_w-1:0] win);
    int         found;
    logic [7:0] b;
    win   = cur_pre;
    found = 0;
    for (int i = 0; i < cur_len; i++) begin
      b   = mem_img[(cur_addr + i / 4) % 256][8 * (i % 4) +: 8];
      win = {win[io_data_w-9:0], b};
      if (win == cur_pat) begin
        if (found <= n) begin
          model_idx = match_idx_t'(i);
        end
        found++;
      end
    end
  endtask

  task automatic load_stimulus();
    int                   fd;
    int                   n;
    string                line;
    string                kind;
    string                name;
    logic [io_data_w-1:0] a;
    logic [io_data_w-1:0] d;
    logic [io_data_w-1:0] e;
    fd = $fopen("bench/accel_stimulus.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open the stimulus file");
    end
    // reset time plus a budget per line
    cycle_limit = 10;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %s %h %h %h", kind, name, a, d, e);
        if (n != 5) begin
          stop_on_error({"malformed line in the stimulus file: ", line});
        end
        if (kind == "M") begin
          mem_img[a[mem_addr_w-1:0]] = d;
        end else begin
          t_kind.push_back(kind);
          t_name.push_back(name);
          t_addr.push_back(a[io_addr_w-1:0]);
          t_data.push_back(d);
          t_exp.push_back(e);
          cycle_limit += 20;
          if (kind == "W" && a[io_addr_w-1:0] == reg_len) begin
            cycle_limit += int'(d[len_w-1:0]);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_step(input int i);
    logic [io_data_w-1:0] rd;
    logic [io_data_w-1:0] win;
    if (t_kind[i] == "W") begin
      write_reg(t_addr[i], t_data[i]);
      if (t_addr[i] == reg_len) cur_len = int'(t_data[i][len_w-1:0]);
      if (t_addr[i] == reg_addr) cur_addr = t_data[i][mem_addr_w-1:0];
      if (t_addr[i] == reg_pattern) cur_pat = t_data[i];
      if (t_addr[i] == reg_preamble) cur_pre = t_data[i];
      if (t_addr[i] == reg_ctrl && t_data[i][0]) begin
        hit_num   = 0;
        mem_lines = 0;
      end
      if (t_addr[i] == reg_release && t_data[i][0]) hit_num++;
    end else if (t_kind[i] == "R") begin
      read_reg(t_addr[i], rd);
      check_word(t_name[i], t_exp[i], rd);
      if (t_addr[i] == reg_state) begin
        model_scan(hit_num, win);
        check_word({t_name[i], "_model"}, win, rd);
      end
    end else if (t_kind[i] == "I") begin
      read_reg(t_addr[i], rd);
      model_scan(hit_num, win);
      check_idx(t_name[i], match_idx_t'(t_exp[i]), match_idx_t'(rd));
      check_idx({t_name[i], "_model"}, model_idx, match_idx_t'(rd));
    end else begin
      stop_on_error({"unknown command kind in the stimulus file: ", t_kind[i]});
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_strb     = '1;
    io_addr     = '0;
    io_wr_data  = '0;
    mem_rd_data = '0;
    mem_req     = 1'b0;
    mem_line    = '0;
    mem_lines   = 0;
    cur_addr    = '0;
    cur_len     = 0;
    cur_pat     = '0;
    cur_pre     = '0;
    hit_num     = 0;
    model_idx   = '0;
    cycle_count = 0;
    // background fill, every line different
    for (int i = 0; i < 256; i++) begin
      mem_img[i] = {8'(~i), 8'(i), 8'(i) ^ 8'ha5, 8'h3c};
    end
    load_stimulus();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < t_kind.size(); i++) begin
      run_step(i);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: src/accel_pkg.sv
package accel_pkg;

  // memory-mapped port
  localparam int io_addr_w = 12;
  localparam int io_data_w = 32;
  localparam int io_strb_w = io_data_w / 8;

  // packet memory, 256 lines of one word
  localparam int mem_addr_w = 8;
  localparam int len_w      = 10;

  // valid bytes in a stream beat, 1 to 4
  typedef logic [2:0] byte_cnt_t;

  // packet offset of the last byte of a hit
  typedef logic [9:0] match_idx_t;

  // register map
  localparam logic [io_addr_w-1:0] reg_ctrl     = 12'h000;
  localparam logic [io_addr_w-1:0] reg_len      = 12'h004;
  localparam logic [io_addr_w-1:0] reg_addr     = 12'h008;
  localparam logic [io_addr_w-1:0] reg_hit_idx  = 12'h00c;
  localparam logic [io_addr_w-1:0] reg_pattern  = 12'h010;
  localparam logic [io_addr_w-1:0] reg_preamble = 12'h014;
  localparam logic [io_addr_w-1:0] reg_state    = 12'h018;
  localparam logic [io_addr_w-1:0] reg_release  = 12'h028;
  localparam logic [io_addr_w-1:0] reg_err      = 12'h404;
  // any address with bit 11 set goes to the blocklist
  localparam logic [io_addr_w-1:0] reg_ip       = 12'h800;

  // blocked IPv4 addresses, host byte order
  localparam int ip_table_len = 8;
  localparam logic [ip_table_len-1:0][io_data_w-1:0] ip_table = {
    32'hc0a80a01,
    32'h0a000005,
    32'hac100204,
    32'h08080808,
    32'hcb007107,
    32'hc6336401,
    32'h5db8d822,
    32'h2d211c0f
  };

endpackage

// File: src/accel_regs.sv
module accel_regs
  import accel_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  io_en,
  input  logic                  io_wen,
  input  logic [io_strb_w-1:0]  io_strb,
  input  logic [io_addr_w-1:0]  io_addr,
  input  logic [io_data_w-1:0]  io_wr_data,
  output logic [io_data_w-1:0]  io_rd_data,
  output logic                  io_rd_valid,
  input  logic                  busy,
  input  logic                  desc_error,
  input  logic                  hit,
  input  match_idx_t            hit_idx,
  input  logic [io_data_w-1:0]  window,
  input  logic                  stream_done,
  input  logic                  ip_hit,
  input  logic                  ip_done,
  output logic                  desc_valid,
  output logic [mem_addr_w-1:0] desc_addr,
  output logic [len_w-1:0]      desc_len,
  output logic                  stop,
  output logic                  reload,
  output logic                  release_hit,
  output logic [io_data_w-1:0]  pattern,
  output logic [io_data_w-1:0]  preamble,
  output logic                  ip_valid,
  output logic [io_data_w-1:0]  ip_addr
);

  logic                 done;
  logic                 rd_stall;
  logic                 rd_req;
  logic                 rd_ready;
  logic [io_data_w-1:0] rd_mux;
  logic [io_data_w-1:0] ip_raw;

  assign rd_req = io_en && !io_wen;
  assign reload = desc_valid;

  // core writes the address as it sits in the packet
  assign ip_addr = {ip_raw[7:0], ip_raw[15:8], ip_raw[23:16], ip_raw[31:24]};

  // read mux and wait condition, both follow the held address
  always_comb begin
    rd_mux   = '0;
    rd_ready = 1'b1;
    if (io_addr[11]) begin
      rd_mux[0] = ip_hit;
      // old result still showing while the new lookup starts
      rd_ready  = ip_done && !ip_valid;
    end else begin
      case (io_addr)
        reg_ctrl: begin
          rd_mux[1] = busy;
          rd_mux[8] = done;
          rd_mux[9] = hit;
        end
        reg_len:      rd_mux[len_w-1:0] = desc_len;
        reg_addr:     rd_mux[mem_addr_w-1:0] = desc_addr;
        reg_hit_idx: begin
          rd_mux[$bits(match_idx_t)-1:0] = hit_idx;
          // ignore flags that a pending reload or release is about to clear
          rd_ready = (done || hit) && !reload && !release_hit;
        end
        reg_pattern:  rd_mux = pattern;
        reg_preamble: rd_mux = preamble;
        reg_state:    rd_mux = window;
        reg_err:      rd_mux[0] = desc_error;
        default:      rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    desc_valid  <= 1'b0;
    stop        <= 1'b0;
    release_hit <= 1'b0;
    ip_valid    <= 1'b0;
    io_rd_valid <= 1'b0;

    // sticky until the next start
    done <= (done || stream_done || stop) && !reload;

    if (io_en && io_wen) begin
      if (io_addr[11]) begin
        ip_raw   <= io_wr_data;
        ip_valid <= 1'b1;
      end else begin
        case (io_addr)
          reg_ctrl: begin
            if (io_strb[0]) begin
              desc_valid <= io_wr_data[0];
              stop       <= io_wr_data[4];
            end
          end
          reg_len:      desc_len    <= io_wr_data[len_w-1:0];
          reg_addr:     desc_addr   <= io_wr_data[mem_addr_w-1:0];
          reg_pattern:  pattern     <= io_wr_data;
          reg_preamble: preamble    <= io_wr_data;
          reg_release:  release_hit <= io_wr_data[0];
          default: ;
        endcase
      end
    end

    // a stalled read re-tests its condition every cycle
    if (rd_req || rd_stall) begin
      io_rd_data  <= rd_mux;
      io_rd_valid <= rd_ready;
      rd_stall    <= !rd_ready;
    end

    if (rst) begin
      desc_valid  <= 1'b0;
      stop        <= 1'b0;
      release_hit <= 1'b0;
      ip_valid    <= 1'b0;
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
      done        <= 1'b0;
    end
  end

  // requester holds the address and stays off the bus for writes
  assert property (@(posedge clk) disable iff (rst)
    rd_stall |-> $stable(io_addr) && !(io_en && io_wen));

endmodule

// File: src/accel_wrap.sv
module accel_wrap
  import accel_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  io_en,
  input  logic                  io_wen,
  input  logic [io_strb_w-1:0]  io_strb,
  input  logic [io_addr_w-1:0]  io_addr,
  input  logic [io_data_w-1:0]  io_wr_data,
  output logic [io_data_w-1:0]  io_rd_data,
  output logic                  io_rd_valid,
  output logic                  mem_en,
  output logic [mem_addr_w-1:0] mem_addr,
  input  logic [io_data_w-1:0]  mem_rd_data
);

  // command side
  logic                  desc_valid;
  logic [mem_addr_w-1:0] desc_addr;
  logic [len_w-1:0]      desc_len;
  logic                  stop;
  logic                  reload;
  logic                  release_hit;
  logic [io_data_w-1:0]  pattern;
  logic [io_data_w-1:0]  preamble;
  logic                  ip_valid;
  logic [io_data_w-1:0]  ip_addr;

  // status side
  logic                  busy;
  logic                  desc_error;
  logic                  stream_done;
  logic                  hit;
  match_idx_t            hit_idx;
  logic [io_data_w-1:0]  window;
  logic                  ip_hit;
  logic                  ip_done;

  // byte stream
  logic [io_data_w-1:0]  s_data;
  byte_cnt_t             s_bytes;
  logic                  s_last;
  logic                  s_valid;
  logic                  s_ready;

  accel_regs i_accel_regs (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .busy(busy), .desc_error(desc_error), .hit(hit), .hit_idx(hit_idx),
    .window(window), .stream_done(stream_done), .ip_hit(ip_hit), .ip_done(ip_done),
    .desc_valid(desc_valid), .desc_addr(desc_addr), .desc_len(desc_len), .stop(stop),
    .reload(reload), .release_hit(release_hit), .pattern(pattern),
    .preamble(preamble), .ip_valid(ip_valid), .ip_addr(ip_addr)
  );

  pkt_rd_dma i_pkt_rd_dma (
    .clk(clk), .rst(rst),
    .desc_valid(desc_valid), .desc_addr(desc_addr), .desc_len(desc_len), .stop(stop),
    .busy(busy), .desc_error(desc_error),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_rd_data(mem_rd_data),
    .s_data(s_data), .s_bytes(s_bytes), .s_last(s_last), .s_valid(s_valid),
    .s_ready(s_ready), .stream_done(stream_done)
  );

  sig_matcher i_sig_matcher (
    .clk(clk), .rst(rst),
    .s_data(s_data), .s_bytes(s_bytes), .s_last(s_last), .s_valid(s_valid),
    .s_ready(s_ready), .reload(reload), .release_hit(release_hit),
    .pattern(pattern), .preamble(preamble),
    .hit(hit), .hit_idx(hit_idx), .window(window)
  );

  ip_blocklist i_ip_blocklist (
    .clk(clk), .rst(rst),
    .ip_valid(ip_valid), .ip_addr(ip_addr), .ip_hit(ip_hit), .ip_done(ip_done)
  );

endmodule

// File: src/ip_blocklist.sv
module ip_blocklist
  import accel_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ip_valid,
  input  logic [io_data_w-1:0] ip_addr,
  output logic                 ip_hit,
  output logic                 ip_done
);

  logic [$clog2(ip_table_len)-1:0] idx;
  logic                            scanning;

  always_ff @(posedge clk) begin
    // one table entry per cycle
    if (scanning) begin
      if (ip_table[idx] == ip_addr) begin
        ip_hit <= 1'b1;
      end
      idx <= idx + 1'b1;
      if (idx == ip_table_len - 1) begin
        scanning <= 1'b0;
        ip_done  <= 1'b1;
      end
    end

    // restart, results held until here
    if (ip_valid) begin
      scanning <= 1'b1;
      idx      <= '0;
      ip_hit   <= 1'b0;
      ip_done  <= 1'b0;
    end

    if (rst) begin
      scanning <= 1'b0;
      idx      <= '0;
      ip_hit   <= 1'b0;
      ip_done  <= 1'b0;
    end
  end

endmodule

// File: src/pkt_rd_dma.sv
module pkt_rd_dma
  import accel_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  desc_valid,
  input  logic [mem_addr_w-1:0] desc_addr,
  input  logic [len_w-1:0]      desc_len,
  input  logic                  stop,
  output logic                  busy,
  output logic                  desc_error,
  output logic                  mem_en,
  output logic [mem_addr_w-1:0] mem_addr,
  input  logic [io_data_w-1:0]  mem_rd_data,
  output logic [io_data_w-1:0]  s_data,
  output byte_cnt_t             s_bytes,
  output logic                  s_last,
  output logic                  s_valid,
  input  logic                  s_ready,
  output logic                  stream_done
);

  logic [len_w-2:0]      lines_left;
  logic [len_w:0]        len_round;
  logic [mem_addr_w-1:0] rd_addr;
  byte_cnt_t             tail_bytes;
  logic                  pend;
  logic                  accept;
  logic                  xfer;

  assign len_round = {1'b0, desc_len} + (len_w + 1)'(3);
  assign accept    = desc_valid && !busy && (desc_len != '0);

  // one line in flight, and none while the matcher holds off
  assign mem_en   = busy && !pend && (lines_left != '0) && s_ready && !stop;
  assign mem_addr = rd_addr;

  assign xfer        = s_valid && s_ready;
  assign stream_done = xfer && s_last;

  always_ff @(posedge clk) begin
    pend <= mem_en;

    if (mem_en) begin
      rd_addr    <= rd_addr + 1'b1;
      lines_left <= lines_left - 1'b1;
    end

    // memory answers one cycle after the request
    if (pend) begin
      s_data  <= mem_rd_data;
      s_valid <= 1'b1;
      s_last  <= (lines_left == '0);
      s_bytes <= (lines_left == '0) ? tail_bytes : byte_cnt_t'(4);
    end else if (xfer) begin
      s_valid <= 1'b0;
    end

    if (stream_done) begin
      busy <= 1'b0;
    end

    if (desc_valid) begin
      if (accept) begin
        busy       <= 1'b1;
        desc_error <= 1'b0;
        rd_addr    <= desc_addr;
        lines_left <= len_round[len_w:2];
        tail_bytes <= (desc_len[1:0] == 2'd0) ? byte_cnt_t'(4) : byte_cnt_t'(desc_len[1:0]);
      end else begin
        desc_error <= 1'b1;
      end
    end

    // abort, late read data is dropped
    if (stop) begin
      busy       <= 1'b0;
      pend       <= 1'b0;
      s_valid    <= 1'b0;
      lines_left <= '0;
    end

    if (rst) begin
      busy       <= 1'b0;
      pend       <= 1'b0;
      s_valid    <= 1'b0;
      lines_left <= '0;
      desc_error <= 1'b0;
    end
  end

  // beat held under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    s_valid && !s_ready && !stop |=> s_valid && $stable(s_data));

endmodule

// File: src/sig_matcher.sv
module sig_matcher
  import accel_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [io_data_w-1:0] s_data,
  input  byte_cnt_t            s_bytes,
  input  logic                 s_last,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic                 reload,
  input  logic                 release_hit,
  input  logic [io_data_w-1:0] pattern,
  input  logic [io_data_w-1:0] preamble,
  output logic                 hit,
  output match_idx_t           hit_idx,
  output logic [io_data_w-1:0] window
);

  logic [1:0]           pos;
  match_idx_t           offset;
  logic                 scan;
  logic [io_data_w-1:0] win_nxt;
  match_idx_t           off_nxt;
  match_idx_t           found_idx;
  logic                 found;
  logic [2:0]           next_pos;
  logic                 beat_end;

  assign scan = s_valid && !hit;

  // walk the beat from pos, low byte first, stop at the first hit
  always_comb begin
    win_nxt   = window;
    off_nxt   = offset;
    found_idx = offset;
    found     = 1'b0;
    next_pos  = {1'b0, pos};
    for (int b = 0; b < io_strb_w; b++) begin
      if (scan && !found && (b >= pos) && (b < s_bytes)) begin
        win_nxt   = {win_nxt[io_data_w-9:0], s_data[8*b +: 8]};
        found_idx = off_nxt;
        found     = (win_nxt == pattern);
        off_nxt   = off_nxt + 1'b1;
        next_pos  = 3'(b + 1);
      end
    end
    // a hit on the final byte still lets the beat go
    beat_end = !found || (next_pos == s_bytes);
  end

  assign s_ready = !hit && beat_end;

  always_ff @(posedge clk) begin
    if (release_hit) begin
      hit <= 1'b0;
    end

    if (scan) begin
      window <= win_nxt;
      // offsets count from zero again after a packet end
      offset <= (s_last && beat_end) ? match_idx_t'(0) : off_nxt;
      pos    <= beat_end ? 2'd0 : next_pos[1:0];
      if (found) begin
        hit     <= 1'b1;
        hit_idx <= found_idx;
      end
    end

    if (reload) begin
      window <= preamble;
      offset <= '0;
      pos    <= '0;
      hit    <= 1'b0;
    end

    if (rst) begin
      offset <= '0;
      pos    <= '0;
      hit    <= 1'b0;
    end
  end

endmodule
